//--- flist.f
+incdir+verif
src/queue_pkg.sv
src/ring_fifo.sv
src/query_fetch.sv
src/issue_select.sv
src/read_queue_top.sv
verif/tb_read_queue.sv

//--- run.sh
#!/bin/sh
# build the read queue testbench with verilator and run it
verilator --binary --timing --assert -Wno-fatal --top-module tb_read_queue \
	-f flist.f -Mdir obj_dir \
	&& ./obj_dir/Vtb_read_queue \
	|| { echo "simulation did not complete cleanly"; exit 1; }

//--- src/issue_select.sv
//========================================
// issue_select
// priority pick of break, paired entry or new read
// registered output toward the forward pipeline
//========================================
`timescale 1ns/1ps
`default_nettype none

module issue_select (
	input  wire logic                      Clk_32UI,
	input  wire logic                      reset_n,
	input  wire queue_pkg::stored_entry_t  entry_head,
	input  wire logic                      entry_not_empty,
	output logic                           entry_pop,
	input  wire queue_pkg::mem_resp_t      mem_head,
	input  wire logic                      mem_not_empty,
	output logic                           mem_pop,
	input  wire logic                      new_valid,
	input  wire queue_pkg::new_read_t      new_in,
	output logic                           new_ready,
	input  wire logic                      out_ready,
	output logic                           out_valid,
	output queue_pkg::issue_t              out
);

	logic              head_break;
	logic              take_pair;
	logic              take_new;
	logic              take_any;
	queue_pkg::issue_t nxt;

	// back to full interval width
	function automatic logic [queue_pkg::IK_W-1:0] widen(
		input logic [queue_pkg::IK_STORE_W-1:0] v
	);
		widen = '0;
		widen[queue_pkg::IK_STORE_W-1:0] = v;
	endfunction

	//========================================
	// source priority
	//========================================
	assign head_break = entry_not_empty && (entry_head.status == queue_pkg::F_BREAK);
	assign take_pair  = !head_break && entry_not_empty && mem_not_empty;
	assign take_new   = !head_break && !take_pair && new_valid;
	assign take_any   = head_break || take_pair || take_new;

	assign entry_pop = out_ready && (head_break || take_pair);
	assign mem_pop   = out_ready && take_pair;
	assign new_ready = out_ready && take_new;  // reads fill idle slots only

	always_comb begin
		nxt = out;  // mem field carries over unless a pair goes out
		if (head_break || take_pair) begin
			nxt.status      = entry_head.status;
			nxt.ptr_curr    = entry_head.ptr_curr;
			nxt.read_num    = entry_head.read_num;
			nxt.ik_x0       = widen(entry_head.ik_x0);
			nxt.ik_x1       = widen(entry_head.ik_x1);
			nxt.ik_x2       = widen(entry_head.ik_x2);
			nxt.ik_info     = '0;
			nxt.ik_info[queue_pkg::INFO_HI_LSB +: queue_pkg::INFO_FIELD_W] = entry_head.info_hi;
			nxt.ik_info[queue_pkg::INFO_FIELD_W-1:0] = entry_head.info_lo;
			nxt.forward_i   = entry_head.forward_i;
			nxt.min_intv    = entry_head.min_intv;
			nxt.backward_x  = entry_head.backward_x;
			nxt.query       = entry_head.query;
			if (take_pair) nxt.mem = mem_head;
		end else if (take_new) begin
			// fresh read enters at its first forward step
			nxt.status      = queue_pkg::F_INIT;
			nxt.ptr_curr    = '0;
			nxt.read_num    = new_in.read_num;
			nxt.ik_x0       = new_in.ik_x0;
			nxt.ik_x1       = new_in.ik_x1;
			nxt.ik_x2       = new_in.ik_x2;
			nxt.ik_info     = new_in.ik_info;
			nxt.forward_i   = new_in.forward_i + 1'b1;
			nxt.min_intv    = new_in.min_intv;
			nxt.backward_x  = new_in.forward_i;
			nxt.query       = '0;  // first round has no base yet
		end
	end

	//========================================
	// output register
	//========================================
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			out_valid <= 1'b0;
		end else if (out_ready) begin
			out_valid <= take_any;
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (out_ready && take_any) out <= nxt;
	end

	// stalled item must stay put until taken
	a_hold_stalled: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		(out_valid && !out_ready) |=> (out_valid && $stable(out)));

endmodule

`default_nettype wire

//--- src/query_fetch.sv
//========================================
// query_fetch
// query ram request for returned entries
// delay line aligning entries with replies
//========================================
`timescale 1ns/1ps
`default_nettype none

module query_fetch (
	input  wire logic                             Clk_32UI,
	input  wire logic                             reset_n,
	input  wire logic                             in_valid,
	input  wire queue_pkg::fwd_entry_t            entry_in,
	output logic                                  query_req_valid,
	output queue_pkg::query_req_t                 query_req,
	input  wire logic [queue_pkg::QUERY_W-1:0]    query_data,
	output logic                                  cap_valid,
	output queue_pkg::stored_entry_t              cap_entry
);

	logic [queue_pkg::QUERY_LATENCY-1:0] v_pipe;
	queue_pkg::fwd_entry_t               e_pipe [queue_pkg::QUERY_LATENCY];
	queue_pkg::fwd_entry_t               last_e;
	queue_pkg::stored_entry_t            narrowed;

	// breaks need no next base
	assign query_req_valid    = in_valid && (entry_in.status != queue_pkg::F_BREAK);
	assign query_req.pos      = entry_in.next_query_pos;
	assign query_req.read_num = entry_in.read_num;
	assign query_req.status   = entry_in.status;

	//========================================
	// wait out the query latency
	//========================================
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			v_pipe    <= '0;
			cap_valid <= 1'b0;
		end else begin
			v_pipe    <= {v_pipe[queue_pkg::QUERY_LATENCY-2:0], in_valid};
			cap_valid <= v_pipe[queue_pkg::QUERY_LATENCY-1];
		end
	end

	always_ff @(posedge Clk_32UI) begin
		e_pipe[0] <= entry_in;
		for (int i = 1; i < queue_pkg::QUERY_LATENCY; i++) begin
			e_pipe[i] <= e_pipe[i-1];
		end
		cap_entry <= narrowed;
	end

	assign last_e = e_pipe[queue_pkg::QUERY_LATENCY-1];

	// reply lines up with the last stage
	always_comb begin
		narrowed.status     = last_e.status;
		narrowed.ptr_curr   = last_e.ptr_curr;
		narrowed.read_num   = last_e.read_num;
		narrowed.ik_x0      = last_e.ik_x0[queue_pkg::IK_STORE_W-1:0];
		narrowed.ik_x1      = last_e.ik_x1[queue_pkg::IK_STORE_W-1:0];
		narrowed.ik_x2      = last_e.ik_x2[queue_pkg::IK_STORE_W-1:0];
		narrowed.info_hi    = last_e.ik_info[queue_pkg::INFO_HI_LSB +: queue_pkg::INFO_FIELD_W];
		narrowed.info_lo    = last_e.ik_info[queue_pkg::INFO_FIELD_W-1:0];
		narrowed.forward_i  = last_e.forward_i;
		narrowed.min_intv   = last_e.min_intv;
		narrowed.backward_x = last_e.backward_x;
		narrowed.query      = query_data;  // whatever the ram drives, 8'hff for a break
	end

endmodule

`default_nettype wire

//--- src/queue_pkg.sv
//========================================
// read queue shared definitions
// field widths, depths and status codes
// packed structs for every datapath item
//========================================
`default_nettype none

package queue_pkg;

	// field widths
	localparam int READ_NUM_W    = 8;
	localparam int POS_W         = 7;
	localparam int STATUS_W      = 6;
	localparam int IK_W          = 64;
	localparam int IK_STORE_W    = 33;  // low bits kept per interval word
	localparam int INFO_FIELD_W  = 7;
	localparam int INFO_HI_LSB   = 32;  // upper ik_info slice starts here
	localparam int QUERY_W       = 8;

	localparam int QUERY_LATENCY = 3;   // query ram round trip
	localparam int ENTRY_DEPTH   = 64;
	localparam int MEM_DEPTH     = 32;

	typedef logic [STATUS_W-1:0] status_t;

	// forward statuses
	localparam status_t F_INIT  = 6'd0;
	localparam status_t F_RUN   = 6'd1;
	localparam status_t F_BREAK = 6'd2;

	// returned from the forward pipeline
	typedef struct packed {
		status_t                 status;
		logic [POS_W-1:0]        ptr_curr;
		logic [READ_NUM_W-1:0]   read_num;
		logic [IK_W-1:0]         ik_x0;
		logic [IK_W-1:0]         ik_x1;
		logic [IK_W-1:0]         ik_x2;
		logic [IK_W-1:0]         ik_info;
		logic [POS_W-1:0]        forward_i;
		logic [POS_W-1:0]        min_intv;
		logic [POS_W-1:0]        backward_x;
		logic [POS_W-1:0]        next_query_pos;
	} fwd_entry_t;

	typedef struct packed {
		logic [POS_W-1:0]        pos;
		logic [READ_NUM_W-1:0]   read_num;
		status_t                 status;
	} query_req_t;

	// narrowed form parked in the entry ring
	typedef struct packed {
		status_t                 status;
		logic [POS_W-1:0]        ptr_curr;
		logic [READ_NUM_W-1:0]   read_num;
		logic [IK_STORE_W-1:0]   ik_x0;
		logic [IK_STORE_W-1:0]   ik_x1;
		logic [IK_STORE_W-1:0]   ik_x2;
		logic [INFO_FIELD_W-1:0] info_hi;  // ik_info[38:32]
		logic [INFO_FIELD_W-1:0] info_lo;  // ik_info[6:0]
		logic [POS_W-1:0]        forward_i;
		logic [POS_W-1:0]        min_intv;
		logic [POS_W-1:0]        backward_x;
		logic [QUERY_W-1:0]      query;
	} stored_entry_t;

	// occurrence counts from dram
	typedef struct packed {
		logic [3:0][31:0]        cnt_a;
		logic [3:0][63:0]        cnt_b;
	} mem_resp_t;

	typedef struct packed {
		logic [READ_NUM_W-1:0]   read_num;
		logic [IK_W-1:0]         ik_x0;
		logic [IK_W-1:0]         ik_x1;
		logic [IK_W-1:0]         ik_x2;
		logic [IK_W-1:0]         ik_info;
		logic [POS_W-1:0]        forward_i;
		logic [POS_W-1:0]        min_intv;
	} new_read_t;

	// toward the forward pipeline
	typedef struct packed {
		status_t                 status;
		logic [POS_W-1:0]        ptr_curr;
		logic [READ_NUM_W-1:0]   read_num;
		logic [IK_W-1:0]         ik_x0;
		logic [IK_W-1:0]         ik_x1;
		logic [IK_W-1:0]         ik_x2;
		logic [IK_W-1:0]         ik_info;
		logic [POS_W-1:0]        forward_i;
		logic [POS_W-1:0]        min_intv;
		logic [POS_W-1:0]        backward_x;
		logic [QUERY_W-1:0]      query;
		mem_resp_t               mem;
	} issue_t;

endpackage

`default_nettype wire

//--- src/read_queue_top.sv
//========================================
// read_queue_top
// query fetch, entry and memory rings, issue
//========================================
`timescale 1ns/1ps
`default_nettype none

module read_queue_top (
	input  wire logic                          Clk_32UI,
	input  wire logic                          reset_n,
	// pipeline returns
	input  wire logic                          in_valid,
	input  wire queue_pkg::fwd_entry_t         entry_in,
	// dram responses
	input  wire logic                          mem_valid,
	input  wire queue_pkg::mem_resp_t          mem_in,
	// fresh reads
	input  wire logic                          new_valid,
	input  wire queue_pkg::new_read_t          new_in,
	output logic                               new_ready,
	// query ram
	output logic                               query_req_valid,
	output queue_pkg::query_req_t              query_req,
	input  wire logic [queue_pkg::QUERY_W-1:0] query_data,
	// forward pipeline
	output logic                               out_valid,
	output queue_pkg::issue_t                  out,
	input  wire logic                          out_ready
);

	logic                     cap_valid;
	queue_pkg::stored_entry_t cap_entry;
	queue_pkg::stored_entry_t entry_head;
	logic                     entry_not_empty;
	logic                     entry_pop;
	queue_pkg::mem_resp_t     mem_head;
	logic                     mem_not_empty;
	logic                     mem_pop;

	query_fetch fetch0 (
		.Clk_32UI        (Clk_32UI),
		.reset_n         (reset_n),
		.in_valid        (in_valid),
		.entry_in        (entry_in),
		.query_req_valid (query_req_valid),
		.query_req       (query_req),
		.query_data      (query_data),
		.cap_valid       (cap_valid),
		.cap_entry       (cap_entry)
	);

	ring_fifo #(.payload_t(queue_pkg::stored_entry_t), .DEPTH(queue_pkg::ENTRY_DEPTH)) entry_ring (
		.Clk_32UI  (Clk_32UI),
		.reset_n   (reset_n),
		.push      (cap_valid),
		.push_data (cap_entry),
		.pop       (entry_pop),
		.head      (entry_head),
		.not_empty (entry_not_empty)
	);

	ring_fifo #(.payload_t(queue_pkg::mem_resp_t), .DEPTH(queue_pkg::MEM_DEPTH)) mem_ring (
		.Clk_32UI  (Clk_32UI),
		.reset_n   (reset_n),
		.push      (mem_valid),  // written on arrival
		.push_data (mem_in),
		.pop       (mem_pop),
		.head      (mem_head),
		.not_empty (mem_not_empty)
	);

	issue_select issue0 (
		.Clk_32UI        (Clk_32UI),
		.reset_n         (reset_n),
		.entry_head      (entry_head),
		.entry_not_empty (entry_not_empty),
		.entry_pop       (entry_pop),
		.mem_head        (mem_head),
		.mem_not_empty   (mem_not_empty),
		.mem_pop         (mem_pop),
		.new_valid       (new_valid),
		.new_in          (new_in),
		.new_ready       (new_ready),
		.out_ready       (out_ready),
		.out_valid       (out_valid),
		.out             (out)
	);

endmodule

`default_nettype wire

//--- src/ring_fifo.sv
//========================================
// ring_fifo
// circular buffer with any payload type
// head read straight from storage
//========================================
`timescale 1ns/1ps
`default_nettype none

module ring_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 4
) (
	input  wire logic     Clk_32UI,
	input  wire logic     reset_n,
	input  wire logic     push,
	input  wire payload_t push_data,
	input  wire logic     pop,
	output payload_t      head,
	output logic          not_empty
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic             full;

	assign full      = (count == CNT_W'(DEPTH));
	assign not_empty = (count != '0);
	assign head      = mem[rd_ptr];

	always_ff @(posedge Clk_32UI) begin
		if (push) mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // idle or both
			endcase
		end
	end

	//========================================
	// producers here cannot stall
	//========================================
	a_no_overflow: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		push |-> (!full || pop));

	a_no_underflow: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		pop |-> not_empty);

endmodule

`default_nettype wire

//--- verif/tb_ref_model.svh
//========================================
// testbench reference model
// lcg, query ram reply, source priority
// expected item toward the forward pipeline
//========================================
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam int          SRC_NONE  = 0;
localparam int          SRC_BREAK = 1;
localparam int          SRC_PAIR  = 2;
localparam int          SRC_NEW   = 3;
localparam logic [63:0] IK_KEEP   = 64'h0000_0001_ffff_ffff;  // low 33 bits
localparam logic [63:0] INFO_KEEP = 64'h0000_007f_0000_007f;  // bits 38..32 and 6..0

// advances the shared seed
function automatic logic [31:0] lcg();
	seed = seed * 32'd1664525 + 32'd1013904223;
	return seed;
endfunction

// never 8'hff, so breaks stand out
function automatic logic [7:0] query_reply(input logic [6:0] pos, input logic [7:0] read_num);
	return {1'b0, pos ^ read_num[6:0]};
endfunction

function automatic int pick_source(input logic head_ok, input logic head_brk,
		input logic mem_ok, input logic nv);
	if (head_brk) return SRC_BREAK;
	if (head_ok && mem_ok) return SRC_PAIR;
	if (nv) return SRC_NEW;
	return SRC_NONE;
endfunction

function automatic queue_pkg::issue_t ref_issue(input int src, input queue_pkg::fwd_entry_t e,
		input logic [7:0] q, input queue_pkg::mem_resp_t m, input queue_pkg::new_read_t n,
		input queue_pkg::issue_t prev);
	queue_pkg::issue_t r;
	if (src == SRC_NEW) begin
		r = '{status: queue_pkg::F_INIT, ptr_curr: 7'd0, read_num: n.read_num, ik_x0: n.ik_x0,
			ik_x1: n.ik_x1, ik_x2: n.ik_x2, ik_info: n.ik_info, forward_i: n.forward_i + 7'd1,
			min_intv: n.min_intv, backward_x: n.forward_i, query: 8'd0, mem: prev.mem};
	end else begin
		r = '{status: e.status, ptr_curr: e.ptr_curr, read_num: e.read_num,
			ik_x0: e.ik_x0 & IK_KEEP, ik_x1: e.ik_x1 & IK_KEEP, ik_x2: e.ik_x2 & IK_KEEP,
			ik_info: e.ik_info & INFO_KEEP, forward_i: e.forward_i, min_intv: e.min_intv,
			backward_x: e.backward_x, query: q, mem: (src == SRC_PAIR) ? m : prev.mem};
	end
	return r;
endfunction

`endif

//--- verif/tb_read_queue.sv
//========================================
// read queue testbench
// clock, reset, stimulus, query ram model
// cycle model, output compare, timeout
//========================================
`timescale 1ns/1ps
`default_nettype none

module tb_read_queue;

	localparam int RESET_CYCLES   = 10;
	localparam int TIMEOUT_CYCLES = 4000;  // about four times reset, 940 stimulus cycles and drain
	localparam int ENTRY_VISIBLE  = queue_pkg::QUERY_LATENCY + 2;  // accept, latency, capture, write

	typedef struct packed {
		int                    ready_at;
		logic [7:0]            query;
		queue_pkg::fwd_entry_t e;
	} ent_slot_t;

	typedef struct packed {
		int                    ready_at;
		queue_pkg::mem_resp_t  m;
	} mem_slot_t;

	logic                  Clk_32UI;
	logic                  reset_n;
	logic                  in_valid;
	queue_pkg::fwd_entry_t entry_in;
	logic                  mem_valid;
	queue_pkg::mem_resp_t  mem_in;
	logic                  new_valid;
	queue_pkg::new_read_t  new_in;
	logic                  new_ready;
	logic                  query_req_valid;
	queue_pkg::query_req_t query_req;
	logic [7:0]            query_data;
	logic                  out_valid;
	queue_pkg::issue_t     out;
	logic                  out_ready;

	logic [31:0]           seed = 32'hbcd1;
	int                    cyc = 0;
	ent_slot_t             ent_q[$];
	mem_slot_t             mem_q[$];
	queue_pkg::new_read_t  new_q[$];
	logic                  exp_valid = 1'b0;
	queue_pkg::issue_t     exp_out;
	int                    n_run = 0;
	int                    n_sent_ent = 0;
	int                    n_iss_ent = 0;
	int                    n_sent_mem = 0;
	int                    n_iss_mem = 0;
	int                    n_sent_new = 0;
	int                    n_iss_new = 0;

	`include "tb_ref_model.svh"

	read_queue_top dut0 (.*);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "run stopped at cycle %0d", cyc);
	endtask

	initial begin : clock_gen
		Clk_32UI = 1'b0;
		forever #10 Clk_32UI = ~Clk_32UI;
	end

	initial begin : watchdog
		forever begin
			@(posedge Clk_32UI);
			cyc++;
			if (cyc >= TIMEOUT_CYCLES) abort_run("timeout, the queue never drained");
		end
	end

	//========================================
	// query ram, reply three edges later
	//========================================
	initial begin : query_ram
		logic [8:0]            cur;
		logic [8:0]            d0;
		logic [8:0]            d1;
		logic [8:0]            d2;
		logic                  exp_qv;
		queue_pkg::query_req_t want;
		d0 = '0;
		d1 = '0;
		d2 = '0;
		query_data = 8'hff;
		forever begin
			@(negedge Clk_32UI);
			exp_qv = in_valid && entry_in.status != queue_pkg::F_BREAK;
			assert (query_req_valid === exp_qv)
				else abort_run($sformatf("Fail query_req_valid got %h exp %h",
					query_req_valid, exp_qv));
			want.pos      = entry_in.next_query_pos;
			want.read_num = entry_in.read_num;
			want.status   = entry_in.status;
			if (query_req_valid) begin
				assert (query_req === want)
					else abort_run($sformatf("Fail query_req got %h exp %h", query_req, want));
			end
			cur = {query_req_valid, query_reply(query_req.pos, query_req.read_num)};
			@(posedge Clk_32UI);
			d2 = d1;
			d1 = d0;
			d0 = cur;
			#2;
			query_data = d2[8] ? d2[7:0] : 8'hff;  // idle ram
		end
	end

	//========================================
	// stimulus, phase 0 reads only, 1 mixed,
	// 2 mixed with stalls, 3 drain
	//========================================
	task automatic drive_cycle(input int phase);
		logic [31:0]           r;
		logic [383:0]          mv;
		logic [7:0]            qv;
		queue_pkg::fwd_entry_t e;
		@(posedge Clk_32UI);
		#2;
		r = lcg();
		out_ready = (phase != 2) || r[24];
		in_valid  = (phase == 1 || phase == 2) && r[3:2] == 2'b00 && ent_q.size() < 48;
		if (in_valid) begin
			e = '{status: (r[5:4] == 2'b00) ? queue_pkg::F_BREAK : queue_pkg::F_RUN,
				ptr_curr: r[14:8], read_num: r[23:16], ik_x0: {lcg(), lcg()},
				ik_x1: {lcg(), lcg()}, ik_x2: {lcg(), lcg()}, ik_info: {lcg(), lcg()},
				forward_i: r[30:24], min_intv: r[13:7], backward_x: r[22:16],
				next_query_pos: r[31:25]};
			qv = (e.status == queue_pkg::F_BREAK) ? 8'hff : query_reply(e.next_query_pos, e.read_num);
			entry_in = e;
			ent_q.push_back(ent_slot_t'{ready_at: cyc + ENTRY_VISIBLE, query: qv, e: e});
			n_sent_ent++;
			if (e.status == queue_pkg::F_RUN) n_run++;
		end
		mem_valid = (phase != 0) && n_sent_mem < n_run && r[6] && mem_q.size() < 28;
		if (mem_valid) begin
			for (int i = 0; i < 12; i++) begin
				mv[i*32 +: 32] = lcg();
			end
			mem_in = mv;
			mem_q.push_back(mem_slot_t'{ready_at: cyc + 1, m: mem_in});  // usable after arrival
			n_sent_mem++;
		end
		if (phase != 3 && new_q.size() < 3 && r[7]) begin
			new_q.push_back(queue_pkg::new_read_t'{read_num: r[31:24], ik_x0: {lcg(), lcg()},
				ik_x1: {lcg(), lcg()}, ik_x2: {lcg(), lcg()}, ik_info: {lcg(), lcg()},
				forward_i: r[14:8], min_intv: r[22:16]});
			n_sent_new++;
		end
		new_valid = new_q.size() > 0;
		if (new_valid) new_in = new_q[0];
	endtask

	initial begin : stimulus
		reset_n   = 1'b0;
		in_valid  = 1'b0;
		entry_in  = '0;
		mem_valid = 1'b0;
		mem_in    = '0;
		new_valid = 1'b0;
		new_in    = '0;
		out_ready = 1'b0;
		repeat (RESET_CYCLES) @(posedge Clk_32UI);
		#2;
		reset_n = 1'b1;
		for (int i = 0; i < 40; i++) drive_cycle(0);
		for (int i = 0; i < 300; i++) drive_cycle(1);
		for (int i = 0; i < 600; i++) drive_cycle(2);
		while (ent_q.size() > 0 || mem_q.size() > 0 || new_q.size() > 0 || n_sent_mem < n_run)
			drive_cycle(3);
		repeat (2) drive_cycle(3);  // last issue gets compared
		if (n_iss_ent == n_sent_ent && n_iss_mem == n_sent_mem && n_iss_new == n_sent_new) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			abort_run("items were lost between the inputs and the output");
		end
	end

	//========================================
	// cycle model and compare
	//========================================
	initial begin : compare
		int        src;
		logic      head_ok;
		logic      head_brk;
		logic      mem_ok;
		logic      exp_nr;
		ent_slot_t he;
		mem_slot_t hm;
		forever begin
			@(negedge Clk_32UI);
			if (!reset_n) begin
				assert (out_valid === 1'b0)
					else abort_run($sformatf("Fail out_valid got %h exp 0 in reset", out_valid));
			end else begin
				assert (out_valid === exp_valid)
					else abort_run($sformatf("Fail out_valid got %h exp %h", out_valid, exp_valid));
				if (exp_valid) begin
					assert (out === exp_out)
						else abort_run($sformatf("Fail out got %h exp %h", out, exp_out));
				end
				// item leaves on the coming edge
				if (out_valid && out_ready) begin
					if (out.status == queue_pkg::F_INIT) begin
						n_iss_new++;
					end else begin
						n_iss_ent++;
						if (out.status == queue_pkg::F_RUN) n_iss_mem++;
					end
				end
				head_ok  = 1'b0;
				head_brk = 1'b0;
				mem_ok   = 1'b0;
				if (ent_q.size() > 0) begin
					head_ok  = (ent_q[0].ready_at <= cyc);
					head_brk = head_ok && (ent_q[0].e.status == queue_pkg::F_BREAK);
				end
				if (mem_q.size() > 0) mem_ok = (mem_q[0].ready_at <= cyc);
				src    = pick_source(head_ok, head_brk, mem_ok, new_valid);
				exp_nr = out_ready && src == SRC_NEW;
				assert (new_ready === exp_nr)
					else abort_run($sformatf("Fail new_ready got %h exp %h", new_ready, exp_nr));
				if (out_ready) begin
					he = '0;
					hm = '0;
					if (src == SRC_BREAK || src == SRC_PAIR) begin
						he = ent_q.pop_front();
					end
					if (src == SRC_PAIR) begin
						hm = mem_q.pop_front();
					end
					if (src == SRC_NEW) begin
						void'(new_q.pop_front());
					end
					if (src != SRC_NONE) begin
						exp_out = ref_issue(src, he.e, he.query, hm.m, new_in, exp_out);
					end
					exp_valid = (src != SRC_NONE);
				end
			end
		end
	end

endmodule

`default_nettype wire
